/* hw/ctrl_pkg.sv */
/* Control core shared definitions
   Bus and settings widths, register map, readback indices and control structs */

package ctrl_pkg;

   // Bus and settings widths
   localparam int WB_DW    = 32;
   localparam int WB_AW    = 16;
   localparam int SET_AW   = 8;
   localparam int RB_IDX_W = 4;

   // Address decode
   localparam int RB_REGION_BIT = 10;
   localparam int SET_ADDR_LSB  = 2;
   localparam int RB_IDX_LSB    = 2;

   ////////////////////
   // Settings register map
   localparam logic [SET_AW-1:0] SR_CLOCK    = 8'd0;
   localparam logic [SET_AW-1:0] SR_SERDES   = 8'd1;
   localparam logic [SET_AW-1:0] SR_ADC      = 8'd2;
   localparam logic [SET_AW-1:0] SR_LED      = 8'd3;
   localparam logic [SET_AW-1:0] SR_PHY      = 8'd4;
   localparam logic [SET_AW-1:0] SR_LED_SRC  = 8'd8;
   localparam logic [SET_AW-1:0] SR_IRQ_CLR  = 8'd16;
   // Two regs: one-shot, then periodic
   localparam logic [SET_AW-1:0] SR_SIMTIMER = 8'd198;

   ////////////////////
   // Readback word indices
   localparam logic [RB_IDX_W-1:0] RB_MODE   = 4'd9;
   localparam logic [RB_IDX_W-1:0] RB_COMPAT = 4'd12;
   localparam logic [RB_IDX_W-1:0] RB_IRQ    = 4'd13;
   localparam logic [RB_IDX_W-1:0] RB_CYCLES = 4'd15;

   // Bump when the register map changes
   localparam logic [WB_DW-1:0] COMPAT_NUM = 32'd3;
   // LEDs 1 to 4 start under hardware control
   localparam logic [7:0] LED_SRC_RESET = 8'b0001_1110;

   ////////////////////
   // Structs
   typedef struct packed {
      logic              stb;
      logic [SET_AW-1:0] addr;
      logic [WB_DW-1:0]  data;
   } set_bus_t;

   typedef struct packed {
      logic             stb;
      logic             cyc;
      logic             we;
      logic [WB_AW-1:0] adr;
      logic [WB_DW-1:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic             ack;
      logic [WB_DW-1:0] dat;
   } wb_rsp_t;

   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_ctrl_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   typedef struct packed {
      logic run_tx;
      logic run_rx;
      logic clk_status;
      logic link_up;
      logic zero;
   } led_hw_t;

endpackage

/* hw/setting_reg.sv */
/* Addressed setting register
   Loads the low bits of a settings write into a typed payload */

module setting_reg import ctrl_pkg::*; #(
   parameter type               payload_t = logic [7:0],
   parameter logic [SET_AW-1:0] ADDR      = '0,
   parameter payload_t          RESET_VAL = '0
) (
   input  logic     wb_clk,
   input  logic     wb_rst,
   input  set_bus_t set_i,
   output payload_t value_o
);

   localparam int PW = $bits(payload_t);

   logic hit;

   assign hit = set_i.stb && (set_i.addr == ADDR);

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         value_o <= RESET_VAL;
      end else if (hit) begin
         value_o <= payload_t'(set_i.data[PW-1:0]);
      end
   end

endmodule

/* hw/wb_slave_ctrl.sv */
/* Bus slave for the control core
   Turns writes into settings strobes and serves the readback window, ack after one cycle */

module wb_slave_ctrl import ctrl_pkg::*; (
   input  logic                wb_clk,
   input  logic                wb_rst,
   input  wb_req_t             req_i,
   output wb_rsp_t             rsp_o,
   output set_bus_t            set_o,
   output logic [RB_IDX_W-1:0] rb_sel_o,
   input  logic [WB_DW-1:0]    rb_data_i
);

   typedef enum logic {
      IDLE,
      ACK
   } state_t;

   state_t           state;
   logic             we_q;
   logic [WB_AW-1:0] adr_q;
   logic [WB_DW-1:0] dat_q;
   logic             rb_region;
   logic             in_ack;

   ////////////////////
   // Two-state FSM
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: if (req_i.stb && req_i.cyc) state <= ACK;
            ACK:  state <= IDLE;
         endcase
      end
   end

   // Request is captured while idle, held through the ack cycle
   always_ff @(posedge wb_clk) begin
      if (state == IDLE) begin
         we_q  <= req_i.we;
         adr_q <= req_i.adr;
         dat_q <= req_i.dat;
      end
   end

   assign in_ack    = (state == ACK);
   assign rb_region = adr_q[RB_REGION_BIT];
   assign rb_sel_o  = adr_q[RB_IDX_LSB +: RB_IDX_W];

   ////////////////////
   // Response and settings strobe
   always_comb begin
      rsp_o.ack  = in_ack;
      // Settings region reads back as zero
      rsp_o.dat  = (in_ack && !we_q && rb_region) ? rb_data_i : '0;
      set_o.stb  = in_ack && we_q && !rb_region;
      set_o.addr = adr_q[SET_ADDR_LSB +: SET_AW];
      set_o.data = dat_q;
   end

endmodule

/* hw/ctrl_outputs.sv */
/* Board control settings
   Clock gen, SERDES, ADC and PHY reset lines, plus the LED hardware/software select */

module ctrl_outputs import ctrl_pkg::*; (
   input  logic         wb_clk,
   input  logic         wb_rst,
   input  set_bus_t     set_i,
   input  led_hw_t      led_hw_i,
   output clock_ctrl_t  clock_o,
   output serdes_ctrl_t serdes_o,
   output adc_ctrl_t    adc_o,
   output logic         phy_resetn_o,
   output logic [7:0]   leds_o
);

   logic       phy_reset;
   logic [7:0] led_sw;
   logic [7:0] led_src;
   logic [7:0] led_hw;

   setting_reg #(.payload_t(clock_ctrl_t), .ADDR(SR_CLOCK)) sr_clock_i (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_i(set_i), .value_o(clock_o));

   setting_reg #(.payload_t(serdes_ctrl_t), .ADDR(SR_SERDES)) sr_serdes_i (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_i(set_i), .value_o(serdes_o));

   setting_reg #(.payload_t(adc_ctrl_t), .ADDR(SR_ADC)) sr_adc_i (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_i(set_i), .value_o(adc_o));

   setting_reg #(.payload_t(logic), .ADDR(SR_PHY)) sr_phy_i (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_i(set_i), .value_o(phy_reset));

   // PHY pin is active low
   assign phy_resetn_o = ~phy_reset;

   ////////////////////
   // LEDs, source bit 1 = hardware, 0 = software
   setting_reg #(.payload_t(logic [7:0]), .ADDR(SR_LED)) sr_led_i (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_i(set_i), .value_o(led_sw));

   setting_reg #(.payload_t(logic [7:0]), .ADDR(SR_LED_SRC), .RESET_VAL(LED_SRC_RESET))
      sr_led_src_i (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_i(set_i), .value_o(led_src));

   assign led_hw = {3'b000, led_hw_i};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

/* hw/sim_timer.sv */
/* Simple countdown timer
   One-shot and periodic pulses, loaded from two consecutive settings */

module sim_timer import ctrl_pkg::*; #(
   parameter logic [SET_AW-1:0] TIMER_BASE = SR_SIMTIMER
) (
   input  logic     wb_clk,
   input  logic     wb_rst,
   input  set_bus_t set_i,
   output logic     onetime_o,
   output logic     periodic_o
);

   logic [WB_DW-1:0] one_cnt;
   logic [WB_DW-1:0] per_cnt;
   logic [WB_DW-1:0] period;

   ////////////////////
   // One-shot, pulses when the count reaches 1, then idles at 0
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         one_cnt <= '0;
      end else if (set_i.stb && set_i.addr == TIMER_BASE) begin
         one_cnt <= set_i.data;
      end else if (one_cnt != '0) begin
         one_cnt <= one_cnt - 1'b1;
      end
   end

   assign onetime_o = (one_cnt == 1);

   ////////////////////
   // Periodic, reloads after each pulse, period 0 stops it
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         period  <= '0;
         per_cnt <= '0;
      end else if (set_i.stb && set_i.addr == TIMER_BASE + 1'b1) begin
         period  <= set_i.data;
         per_cnt <= set_i.data;
      end else if (period != '0) begin
         per_cnt <= (per_cnt == 1) ? period : per_cnt - 1'b1;
      end
   end

   assign periodic_o = (period != '0) && (per_cnt == 1);

endmodule

/* hw/irq_latch.sv */
/* Interrupt pending register
   Sticky timer interrupts, write-one-to-clear, single combined interrupt */

module irq_latch import ctrl_pkg::*; (
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  set_bus_t   set_i,
   input  logic       onetime_i,
   input  logic       periodic_i,
   output logic [1:0] pending_o,
   output logic       irq_o
);

   logic [1:0] clr_mask;
   logic [1:0] pending_nxt;

   assign clr_mask = (set_i.stb && set_i.addr == SR_IRQ_CLR) ? set_i.data[1:0] : 2'b00;

   // A new pulse beats a clear in the same cycle
   assign pending_nxt = (pending_o & ~clr_mask) | {periodic_i, onetime_i};

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         pending_o <= 2'b00;
         irq_o     <= 1'b0;
      end else begin
         pending_o <= pending_nxt;
         irq_o     <= |pending_nxt;
      end
   end

endmodule

/* hw/readback_mux.sv */
/* Status readback
   Free-running cycle counter and selection of the readback words */

module readback_mux import ctrl_pkg::*; #(
   parameter logic [WB_DW-1:0] COMPAT = COMPAT_NUM
) (
   input  logic                wb_clk,
   input  logic                wb_rst,
   input  logic [RB_IDX_W-1:0] sel_i,
   input  logic [1:0]          pending_i,
   input  logic                sim_mode_i,
   input  logic [3:0]          clock_divider_i,
   output logic [WB_DW-1:0]    data_o
);

   logic [WB_DW-1:0] cycle_count;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         cycle_count <= '0;
      end else begin
         cycle_count <= cycle_count + 1'b1;
      end
   end

   ////////////////////
   // Word select, unused words read zero
   always_comb begin
      case (sel_i)
         RB_MODE:   data_o = {sim_mode_i, 27'd0, clock_divider_i};
         RB_COMPAT: data_o = COMPAT;
         RB_IRQ:    data_o = {30'd0, pending_i};
         RB_CYCLES: data_o = cycle_count;
         default:   data_o = '0;
      endcase
   end

endmodule

/* hw/u2_ctrl_top.sv */
/* Control and status core top level
   Bus slave, board control registers, timer, interrupts and readback */

module u2_ctrl_top import ctrl_pkg::*; #(
   parameter logic [WB_DW-1:0]  COMPAT     = COMPAT_NUM,
   parameter logic [SET_AW-1:0] TIMER_BASE = SR_SIMTIMER
) (
   input  logic         wb_clk,
   input  logic         wb_rst,
   input  wb_req_t      wb_req_i,
   output wb_rsp_t      wb_rsp_o,
   input  led_hw_t      led_hw_i,
   input  logic         sim_mode_i,
   input  logic [3:0]   clock_divider_i,
   output clock_ctrl_t  clock_o,
   output serdes_ctrl_t serdes_o,
   output adc_ctrl_t    adc_o,
   output logic         phy_resetn_o,
   output logic [7:0]   leds_o,
   output logic         irq_o
);

   set_bus_t            set_bus;
   logic [RB_IDX_W-1:0] rb_sel;
   logic [WB_DW-1:0]    rb_data;
   logic                onetime;
   logic                periodic;
   logic [1:0]          pending;

   ////////////////////
   // Bus slave
   wb_slave_ctrl wb_slave_ctrl_i (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_i(wb_req_i), .rsp_o(wb_rsp_o), .set_o(set_bus),
      .rb_sel_o(rb_sel), .rb_data_i(rb_data));

   // Board control lines and LEDs
   ctrl_outputs ctrl_outputs_i (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_i(set_bus), .led_hw_i(led_hw_i),
      .clock_o(clock_o), .serdes_o(serdes_o), .adc_o(adc_o),
      .phy_resetn_o(phy_resetn_o), .leds_o(leds_o));

   ////////////////////
   // Timer and interrupts
   sim_timer #(.TIMER_BASE(TIMER_BASE)) sim_timer_i (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_i(set_bus),
      .onetime_o(onetime), .periodic_o(periodic));

   irq_latch irq_latch_i (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_i(set_bus),
      .onetime_i(onetime), .periodic_i(periodic),
      .pending_o(pending), .irq_o(irq_o));

   // Status readback
   readback_mux #(.COMPAT(COMPAT)) readback_mux_i (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .sel_i(rb_sel), .pending_i(pending),
      .sim_mode_i(sim_mode_i), .clock_divider_i(clock_divider_i), .data_o(rb_data));

endmodule

/* testbench/tb_clock_gen.sv */
/* Testbench clock and reset
   Free-running wb_clk and a synchronous reset held for the first cycles */

module tb_clock_gen #(
   parameter int PERIOD_NS    = 4,
   parameter int RESET_CYCLES = 4
) (
   output logic wb_clk,
   output logic wb_rst
);

   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      wb_clk = 1'b0;
      forever #(PERIOD_NS / 2) wb_clk = ~wb_clk;
   end

   initial begin
      wb_rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge wb_clk);
      wb_rst <= 1'b0;
   end

endmodule

/* testbench/tb_u2_ctrl.sv */
/* Testbench for the control and status core
   Runs the vectors of the tests file over the bus and the pins, under a watchdog */

module tb_u2_ctrl import ctrl_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int    CLK_PERIOD  = 4;
   localparam int    ACK_LIMIT   = 8;
   localparam int    LINE_BUDGET = 20;
   localparam string TESTS_FILE  = "testbench/ctrl_tests.txt";

   logic         wb_clk;
   logic         wb_rst;
   wb_req_t      wb_req;
   wb_rsp_t      wb_rsp;
   led_hw_t      led_hw;
   logic         sim_mode;
   logic [3:0]   clock_divider;
   clock_ctrl_t  clock_ctrl;
   serdes_ctrl_t serdes_ctrl;
   adc_ctrl_t    adc_ctrl;
   logic         phy_resetn;
   logic [7:0]   leds;
   logic         irq;

   // Vectors, one entry per line of the tests file
   string       op_q[$];
   string       tgt_q[$];
   string       dat_q[$];
   string       exp_q[$];
   // Last value written to each setting address
   logic [31:0] shadow [0:255];
   logic [31:0] last_rdat;
   int          seed;
   int          mismatch_count;
   int          ack_timeouts;
   int          other_errors;
   int          budget_cycles;
   logic        tests_loaded;

   tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(4)) tb_clock_gen_i (
      .wb_clk(wb_clk), .wb_rst(wb_rst));

   u2_ctrl_top u2_ctrl_top_i (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp),
      .led_hw_i(led_hw), .sim_mode_i(sim_mode), .clock_divider_i(clock_divider),
      .clock_o(clock_ctrl), .serdes_o(serdes_ctrl), .adc_o(adc_ctrl),
      .phy_resetn_o(phy_resetn), .leds_o(leds), .irq_o(irq));

   task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                              input string what);
      if (got !== expected) begin
         $display("MISMATCH at %0d ns: %s, got %08h, expected %08h",
                  $time, what, got, expected);
         mismatch_count++;
      end
   endtask

   // Each LED shows hardware where its source bit is set, software otherwise
   function automatic logic [7:0] led_expect(input logic [7:0] src, input logic [7:0] sw,
                                             input logic [7:0] hw);
      logic [7:0] result;
      for (int i = 0; i < 8; i++) begin
         result[i] = src[i] ? hw[i] : sw[i];
      end
      return result;
   endfunction

   ////////////////////
   // Tests file
   task automatic load_tests();
      int    fd;
      int    n;
      string line;
      string op;
      string tgt;
      string dat;
      string expv;
      fd = $fopen(TESTS_FILE, "r");
      if (fd == 0) begin
         $display("Could not open the tests file %s", TESTS_FILE);
         other_errors++;
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 0 && line.len() > 1 && line[0] != "#") begin
            n = $sscanf(line, "%s %s %s %s", op, tgt, dat, expv);
            if (n == 4) begin
               op_q.push_back(op);
               tgt_q.push_back(tgt);
               dat_q.push_back(dat);
               exp_q.push_back(expv);
               if (op == "T") budget_cycles += dat.atoi();
               budget_cycles += LINE_BUDGET;
            end else begin
               $display("Malformed line in the tests file: %s", line);
               other_errors++;
            end
         end
      end
      $fclose(fd);
      tests_loaded = (budget_cycles > 0);
   endtask

   ////////////////////
   // Bus access, holds the request until ack
   task automatic bus_access(input logic we, input logic [15:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
      int   waited;
      logic got_ack;
      waited  = 0;
      got_ack = 1'b0;
      rdat    = '0;
      @(posedge wb_clk);
      wb_req.stb <= 1'b1;
      wb_req.cyc <= 1'b1;
      wb_req.we  <= we;
      wb_req.adr <= adr;
      wb_req.dat <= wdat;
      while (!got_ack && waited < ACK_LIMIT) begin
         @(negedge wb_clk);
         waited++;
         if (wb_rsp.ack) begin
            got_ack = 1'b1;
            rdat    = wb_rsp.dat;
         end
      end
      if (!got_ack) begin
         $display("No ack from the DUT within %0d cycles for address %04h", ACK_LIMIT, adr);
         ack_timeouts++;
      end
      @(posedge wb_clk);
      wb_req.stb <= 1'b0;
      wb_req.cyc <= 1'b0;
      wb_req.we  <= 1'b0;
   endtask

   // Pin group value, and what the written settings say it should be
   task automatic pin_value(input string group, output logic [31:0] got,
                            output logic [31:0] calc, output logic known);
      got   = '0;
      calc  = '0;
      known = 1'b1;
      if (group == "CLOCK") begin
         got  = {27'd0, clock_ctrl};
         calc = {27'd0, shadow[SR_CLOCK][4:0]};
      end else if (group == "SERDES") begin
         got  = {28'd0, serdes_ctrl};
         calc = {28'd0, shadow[SR_SERDES][3:0]};
      end else if (group == "ADC") begin
         got  = {28'd0, adc_ctrl};
         calc = {28'd0, shadow[SR_ADC][3:0]};
      end else if (group == "PHYN") begin
         got  = {31'd0, phy_resetn};
         calc = {31'd0, ~shadow[SR_PHY][0]};
      end else if (group == "LEDS") begin
         got  = {24'd0, leds};
         calc = {24'd0, led_expect(shadow[SR_LED_SRC][7:0], shadow[SR_LED][7:0],
                                   {3'b000, led_hw})};
      end else if (group == "IRQ") begin
         got   = {31'd0, irq};
         known = 1'b0;
      end else begin
         $display("Unknown pin group %s in the tests file", group);
         other_errors++;
         known = 1'b0;
      end
   endtask

   task automatic run_line(input int idx);
      string       op;
      string       expv;
      logic [31:0] adr;
      logic [31:0] data;
      logic [31:0] rdat;
      logic [31:0] got;
      logic [31:0] calc;
      logic        known;
      op   = op_q[idx];
      expv = exp_q[idx];
      adr  = '0;
      if (op == "W") begin
         adr = tgt_q[idx].atohex();
         if (dat_q[idx] == "RAND") data = $random(seed);
         else data = dat_q[idx].atohex();
         bus_access(1'b1, adr[15:0], data, rdat);
         if (!adr[RB_REGION_BIT]) shadow[adr[9:2]] = data;
      end else if (op == "R") begin
         adr = tgt_q[idx].atohex();
         bus_access(1'b0, adr[15:0], 32'd0, rdat);
         if (expv == "INC") begin
            check_value({31'd0, rdat > last_rdat}, 32'd1,
                        $sformatf("read of %03h not above %08h", adr[15:0], last_rdat));
         end else if (expv != "-") begin
            check_value(rdat, expv.atohex(), $sformatf("read of %03h", adr[15:0]));
         end
         last_rdat = rdat;
      end else if (op == "P") begin
         @(negedge wb_clk);
         pin_value(tgt_q[idx], got, calc, known);
         if (expv != "CALC") begin
            check_value(got, expv.atohex(), {"pins ", tgt_q[idx]});
         end else if (known) begin
            check_value(got, calc, {"pins ", tgt_q[idx]});
         end else begin
            $display("No expected value rule for pin group %s", tgt_q[idx]);
            other_errors++;
         end
      end else if (op == "T") begin
         repeat (dat_q[idx].atoi()) @(posedge wb_clk);
      end else begin
         $display("Unknown operation %s on test line %0d", op, idx);
         other_errors++;
      end
   endtask

   ////////////////////
   // Main sequence
   initial begin
      seed           = 80;
      mismatch_count = 0;
      ack_timeouts   = 0;
      other_errors   = 0;
      budget_cycles  = 0;
      tests_loaded   = 1'b0;
      last_rdat      = '0;
      wb_req         = '0;
      led_hw         = '0;
      sim_mode       = 1'b0;
      clock_divider  = 4'd0;
      foreach (shadow[a]) shadow[a] = '0;
      // LEDs 1 to 4 under hardware control after reset
      shadow[SR_LED_SRC] = 32'h0000_001E;
      load_tests();
      wait (wb_rst === 1'b0);
      @(posedge wb_clk);
      led_hw        <= 5'b10111;
      sim_mode      <= 1'b1;
      clock_divider <= 4'hA;
      for (int i = 0; i < op_q.size(); i++) begin
         run_line(i);
      end
      repeat (2) @(posedge wb_clk);
      $display("Errors: %0d mismatches, %0d missing acks, %0d other",
               mismatch_count, ack_timeouts, other_errors);
      if (mismatch_count + ack_timeouts + other_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Watchdog, budget taken from the tests file
   initial begin
      wait (tests_loaded);
      #(budget_cycles * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, the tests did not complete",
               budget_cycles);
      $display("TEST FAILED");
      $finish;
   end

endmodule

/* filelist.f */
hw/ctrl_pkg.sv
hw/setting_reg.sv
hw/wb_slave_ctrl.sv
hw/ctrl_outputs.sv
hw/sim_timer.sv
hw/irq_latch.sv
hw/readback_mux.sv
hw/u2_ctrl_top.sv
testbench/tb_clock_gen.sv
testbench/tb_u2_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the control core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
   --top-module tb_u2_ctrl -f filelist.f -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TEST FAILED" sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"

/* testbench/ctrl_tests.txt */
# op target data expect (hex, T cycles in decimal); - is an unused field
# W addr data -, R addr - expect, P pins - expect, T - cycles -
# Reset, led_hw_i 17, sim_mode_i 1, clock_divider_i A
R 430 - 3
P LEDS - 16
P IRQ - 0
P PHYN - 1
R 00C - 0
# Control writes
W 000 RAND -
P CLOCK - CALC
W 004 RAND -
P SERDES - CALC
W 008 RAND -
P ADC - CALC
W 010 RAND -
P PHYN - CALC
# LED select
W 00C RAND -
W 020 RAND -
P LEDS - CALC
W 020 RAND -
P LEDS - CALC
# One-shot timer, 50 cycles
W 318 32 -
R 434 - 0
T - 60 -
R 434 - 1
P IRQ - 1
W 040 1 -
R 434 - 0
P IRQ - 0
# Periodic timer, 10 cycles
W 31C A -
T - 30 -
R 434 - 2
W 31C 0 -
W 040 2 -
T - 30 -
R 434 - 0
P IRQ - 0
# Readback words
R 424 - 8000000A
R 43C - -
R 43C - INC
R 400 - 0
